// ==== Makefile ====
SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: obj_dir/Vmandel_display_tb

obj_dir/Vmandel_display_tb: mandel_display.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module mandel_display_tb -f mandel_display.f

run: obj_dir/Vmandel_display_tb
	@out="$$(./obj_dir/Vmandel_display_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// ==== frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer
	import vga_pkg::*;
	import render_pkg::*;
#(
	parameter int h_active = 640,
	parameter int v_active = 480
) (
	input  logic               M10k_pll,
	input  fb_write_t          fb_write,
	input  logic [coord_w-1:0] next_x,
	input  logic [coord_w-1:0] next_y,
	output color_t             pixel
);

	// each bank holds every other screen row
	localparam int depth = h_active * v_active / 2;
	localparam int idx_w = $clog2(depth);

	logic [addr_w-1:0]  read_addr;
	color_t [lanes-1:0] bank_q;
	// row parity of the word now on bank_q
	logic               odd_row_q;

	// halve the screen row to get the bank row
	assign read_addr = addr_w'(h_active) * addr_w'(next_y[coord_w-1:1]) + addr_w'(next_x);

	////////////////////
	// banks
	////////////////////

	for (genvar i = 0; i < lanes; i++) begin : g_bank
		color_t mem [depth];
		color_t rd_q;

		// shared write address, lane i data
		// read-during-write gives the old word
		always_ff @(posedge M10k_pll) begin
			if (fb_write.we) begin
				mem[fb_write.addr[idx_w-1:0]] <= fb_write.data[i];
			end
			rd_q <= mem[read_addr[idx_w-1:0]];
		end

		assign bank_q[i] = rd_q;
	end

	// parity follows the read by one cycle
	always_ff @(posedge M10k_pll) begin
		odd_row_q <= next_y[0];
	end

	// even rows from bank 0, odd rows from bank 1
	assign pixel = bank_q[odd_row_q];

endmodule

// ==== mandel_display.f ====
vga_pkg.sv
render_pkg.sv
vga_timing.sv
frame_buffer.sv
render_sequencer.sv
mandel_display_top.sv
mandel_display_assertions.sv
mandel_display_tb.sv

// ==== mandel_display_assertions.sv ====
`timescale 1ns/1ps

module mandel_display_assertions
	import render_pkg::*;
(
	input logic             M10k_pll,
	input logic             reset,
	input logic             solver_start,
	input logic [lanes-1:0] lane_done,
	input fb_write_t        fb_write,
	input logic             frame_toggle,
	input logic             scan_enable
);

	// write strobe is a single cycle
	assert property (@(posedge M10k_pll) disable iff (reset)
		fb_write.we |=> !fb_write.we)
		else $error("fb_write.we held longer than one cycle");

	// start, then settle and wait, before any write
	assert property (@(posedge M10k_pll) disable iff (reset)
		solver_start |=> !fb_write.we ##1 !fb_write.we)
		else $error("write too soon after solver_start");

	// write only on a cycle after every lane was done
	assert property (@(posedge M10k_pll) disable iff (reset)
		$rose(fb_write.we) |-> $past(&lane_done))
		else $error("write issued before all lanes were done");

	// control outputs stay low while reset is applied
	assert property (@(posedge M10k_pll)
		$past(reset) |-> !(solver_start || fb_write.we || frame_toggle || scan_enable))
		else $error("control output high during reset");

endmodule

bind render_sequencer mandel_display_assertions u_assertions (
	.M10k_pll    (M10k_pll),
	.reset       (reset),
	.solver_start(solver_start),
	.lane_done   (lane_done),
	.fb_write    (fb_write),
	.frame_toggle(frame_toggle),
	.scan_enable (scan_enable)
);

// ==== mandel_display_tb.sv ====
`timescale 1ns/1ps

module mandel_display_tb
	import vga_pkg::*;
	import render_pkg::*;
;

	localparam int h_act = 16;
	localparam int v_act = 8;
	// cycles per line and lines per frame for the small geometry
	localparam int line_len = 16 + 4 + 6 + 4;
	localparam int frame_lines = 8 + 2 + 2 + 2;
	localparam int pixels = h_act * v_act / 2;

	logic               M10k_pll;
	logic               reset;
	logic [lanes-1:0]   lane_done;
	color_t [lanes-1:0] lane_color;
	logic               solver_start;
	pixel_req_t         pixel_req;
	logic               frame_toggle;
	vga_out_t           vga;

	logic [31:0] lfsr = 32'haf7f_285a;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int tests_bad = 0;
	logic timed_out = 1'b0;

	// lane model state
	logic [7:0] ref_img [v_act][h_act];
	int  delay [lanes];
	logic busy [lanes];
	logic held [lanes];
	logic hold = 1'b0;
	logic long_delay = 1'b0;

	// request and frame tracking
	int  exp_x = 0;
	int  exp_row = 0;
	logic pending = 1'b0;
	logic answered = 1'b0;
	int  req_in_frame = 0;
	int  req_total = 0;
	int  req_at_toggle = 0;
	int  toggles = 0;
	logic prev_toggle = 1'b0;

	// sync measurement
	logic prev_hs = 1'b1;
	logic prev_vs = 1'b1;
	int  hs_low = 0;
	int  vs_low = 0;
	int  line_cnt = 0;
	int  frame_cnt = 0;
	logic have_hfall = 1'b0;
	logic have_vfall = 1'b0;
	int  lines_measured = 0;
	int  frames_measured = 0;

	mandel_display_top #(
		.h_active(16),
		.h_front (4),
		.h_pulse (6),
		.h_back  (4),
		.v_active(8),
		.v_front (2),
		.v_pulse (2),
		.v_back  (2)
	) u_dut (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.lane_done   (lane_done),
		.lane_color  (lane_color),
		.solver_start(solver_start),
		.pixel_req   (pixel_req),
		.frame_toggle(frame_toggle),
		.vga         (vga)
	);

	always #10 M10k_pll = ~M10k_pll;

	////////////////////
	// helpers
	////////////////////

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit
	function automatic int take_bits(input int n);
		int r;
		r = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			r = (r << 1) | int'(lfsr[0]);
		end
		return r;
	endfunction

	task automatic check(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, act);
		end
	endtask

	// a timed-out wait ends every later wait at once
	task automatic flag_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timed_out = 1'b1;
	endtask

	task automatic report(input string name, input int err_before);
		tests++;
		if (timed_out) begin
			tests_bad++;
			$display("test %s: timed out", name);
		end else if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic wait_toggles(input int target, input int limit);
		int n;
		n = 0;
		while (!timed_out && toggles < target) begin
			@(posedge M10k_pll);
			n++;
			if (n > limit) flag_timeout("frame_toggle");
		end
	endtask

	////////////////////
	// lane model
	////////////////////

	always @(posedge M10k_pll) begin
		logic [7:0] c;
		if (!reset && solver_start) begin
			for (int i = 0; i < lanes; i++) begin
				lane_done[i] <= 1'b0;
				delay[i] = take_bits(4);
				// lane 1 stretched for the back-pressure test
				if (long_delay && i == 1) delay[i] = 40 + take_bits(6);
				busy[i] = 1'b1;
				held[i] = hold;
			end
		end else if (!reset) begin
			for (int i = 0; i < lanes; i++) begin
				if (busy[i] && !(held[i] && hold)) begin
					if (delay[i] == 0) begin
						c = 8'(take_bits(8));
						lane_done[i] <= 1'b1;
						lane_color[i] <= c;
						// lane i renders screen row 2*row+i
						ref_img[2 * int'(pixel_req.row) + i][int'(pixel_req.x)] = c;
						busy[i] = 1'b0;
					end else begin
						delay[i]--;
					end
				end
			end
		end
	end

	////////////////////
	// monitors
	////////////////////

	always @(posedge M10k_pll) begin
		if (!reset) begin
			// frame marker, one per pass of requests
			if (frame_toggle != prev_toggle) begin
				toggles++;
				check("requests per frame", (toggles == 1) ? 0 : pixels, req_in_frame);
				req_in_frame = 0;
				req_at_toggle = req_total;
			end
			prev_toggle = frame_toggle;
			if (solver_start) begin
				if (pending && !answered) begin
					errors++;
					$display("%0t solver_start came before both lanes were done", $time);
				end
				check("pixel_req.x", exp_x, int'(pixel_req.x));
				check("pixel_req.row", exp_row, int'(pixel_req.row));
				// raster order over the buffer
				if (exp_x == h_act - 1) begin
					exp_x = 0;
					exp_row = (exp_row == v_act / 2 - 1) ? 0 : exp_row + 1;
				end else begin
					exp_x++;
				end
				pending = 1'b1;
				answered = 1'b0;
				req_in_frame++;
				req_total++;
			end else if (pending && lane_done == 2'b11) begin
				answered = 1'b1;
			end
			// hsync width and line period
			line_cnt++;
			frame_cnt++;
			if (!vga.hsync) hs_low++;
			if (prev_hs && !vga.hsync) begin
				if (have_hfall) begin
					check("line period", line_len, line_cnt);
					lines_measured++;
				end
				line_cnt = 0;
				have_hfall = 1'b1;
			end
			if (!prev_hs && vga.hsync) begin
				check("hsync low", 6, hs_low);
				hs_low = 0;
			end
			// vsync in whole lines
			if (!vga.vsync) vs_low++;
			if (prev_vs && !vga.vsync) begin
				if (have_vfall) begin
					check("frame period", frame_lines * line_len, frame_cnt);
					frames_measured++;
				end
				frame_cnt = 0;
				have_vfall = 1'b1;
			end
			if (!prev_vs && vga.vsync) begin
				check("vsync low", 2 * line_len, vs_low);
				vs_low = 0;
			end
			prev_hs = vga.hsync;
			prev_vs = vga.vsync;
		end
	end

	////////////////////
	// test sequence
	////////////////////

	task automatic check_idle_outputs();
		check("solver_start", 0, int'(solver_start));
		check("frame_toggle", 0, int'(frame_toggle));
		check("vga.blank_n", 0, int'(vga.blank_n));
		check("vga.hsync", 1, int'(vga.hsync));
		check("vga.vsync", 1, int'(vga.vsync));
		check("vga.red", 0, int'(vga.red));
		check("vga.green", 0, int'(vga.green));
		check("vga.blue", 0, int'(vga.blue));
	endtask

	task automatic check_image();
		int n;
		int k;
		int x;
		int y;
		logic [7:0] c;
		logic pv;
		// wait for vsync to come back high
		n = 0;
		pv = vga.vsync;
		while (!timed_out) begin
			@(posedge M10k_pll);
			n++;
			if (!pv && vga.vsync) break;
			if (n > 2 * frame_lines * line_len) flag_timeout("vsync rising edge");
			pv = vga.vsync;
		end
		n = 0;
		k = 0;
		while (!timed_out && k < h_act * v_act) begin
			@(posedge M10k_pll);
			n++;
			if (n > 2 * frame_lines * line_len) begin
				flag_timeout("active pixels");
			end else if (vga.blank_n) begin
				x = k % h_act;
				y = k / h_act;
				c = ref_img[y][x];
				check("vga.red", int'({c[7:5], 5'b0}), int'(vga.red));
				check("vga.green", int'({c[4:2], 5'b0}), int'(vga.green));
				check("vga.blue", int'({c[1:0], 6'b0}), int'(vga.blue));
				k++;
			end
		end
	endtask

	initial begin
		int e;
		int n;
		M10k_pll = 1'b0;
		reset = 1'b1;
		lane_done = '0;
		lane_color = '0;
		for (int i = 0; i < lanes; i++) begin
			busy[i] = 1'b0;
			held[i] = 1'b0;
			delay[i] = 0;
		end

		// 1: reset state
		e = errors;
		repeat (8) @(posedge M10k_pll);
		@(negedge M10k_pll);
		check_idle_outputs();
		repeat (8) @(posedge M10k_pll);
		reset <= 1'b0;
		@(negedge M10k_pll);
		check_idle_outputs();
		report("reset state", e);

		// 2: first full frame in raster order
		e = errors;
		wait_toggles(2, 5000);
		report("request order", e);

		// 3: one lane held off for long
		e = errors;
		long_delay <= 1'b1;
		wait_toggles(3, 20000);
		long_delay <= 1'b0;
		report("back-pressure", e);

		// 4: two full passes of requests before the third marker
		e = errors;
		check("requests before third toggle", 2 * pixels, req_at_toggle);
		report("frame marker", e);

		// 5: sync widths and periods
		e = errors;
		if (lines_measured == 0) begin
			errors++;
			$display("no line period was measured");
		end
		if (frames_measured == 0) begin
			errors++;
			$display("no frame period was measured");
		end
		report("sync shape", e);

		// 6: freeze rendering after this frame, then scan it
		e = errors;
		n = 0;
		while (!timed_out && req_in_frame < pixels) begin
			@(posedge M10k_pll);
			n++;
			if (n > 5000) flag_timeout("last request of the frame");
		end
		hold <= 1'b1;
		wait_toggles(4, 5000);
		check_image();
		hold <= 1'b0;
		repeat (40) @(posedge M10k_pll);
		report("displayed image", e);

		$display("tests %0d, bad %0d, checks %0d, errors %0d", tests, tests_bad, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== mandel_display_top.sv ====
`timescale 1ns/1ps

module mandel_display_top
	import vga_pkg::*;
	import render_pkg::*;
#(
	parameter int h_active = 640,
	parameter int h_front  = 16,
	parameter int h_pulse  = 96,
	parameter int h_back   = 48,
	parameter int v_active = 480,
	parameter int v_front  = 10,
	parameter int v_pulse  = 2,
	parameter int v_back   = 33
) (
	input  logic               M10k_pll,
	input  logic               reset,
	input  logic [lanes-1:0]   lane_done,
	input  color_t [lanes-1:0] lane_color,
	output logic               solver_start,
	output pixel_req_t         pixel_req,
	output logic               frame_toggle,
	output vga_out_t           vga
);

	// write side
	fb_write_t          fb_write;
	// scan held off until the first frame begins
	logic               scan_enable;
	// read side
	logic [coord_w-1:0] next_x;
	logic [coord_w-1:0] next_y;
	color_t             pixel;

	////////////////////
	// render side
	////////////////////

	render_sequencer #(
		.h_active(h_active),
		.v_active(v_active)
	) u_sequencer (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.lane_done   (lane_done),
		.lane_color  (lane_color),
		.solver_start(solver_start),
		.pixel_req   (pixel_req),
		.fb_write    (fb_write),
		.frame_toggle(frame_toggle),
		.scan_enable (scan_enable)
	);

	// row-interleaved storage, one bank per lane
	frame_buffer #(
		.h_active(h_active),
		.v_active(v_active)
	) u_frame_buffer (
		.M10k_pll(M10k_pll),
		.fb_write(fb_write),
		.next_x  (next_x),
		.next_y  (next_y),
		.pixel   (pixel)
	);

	////////////////////
	// display side
	////////////////////

	vga_timing #(
		.h_active(h_active),
		.h_front (h_front),
		.h_pulse (h_pulse),
		.h_back  (h_back),
		.v_active(v_active),
		.v_front (v_front),
		.v_pulse (v_pulse),
		.v_back  (v_back)
	) u_vga_timing (
		.M10k_pll   (M10k_pll),
		.reset      (reset),
		.scan_enable(scan_enable),
		.pixel      (pixel),
		.next_x     (next_x),
		.next_y     (next_y),
		.vga        (vga)
	);

endmodule

// ==== render_pkg.sv ====
package render_pkg;
	import vga_pkg::*;

	////////////////////
	// lane layout
	////////////////////

	// two engines, so one row bit picks the bank
	localparam int lanes = 2;

	// word address into a bank, wide enough for 640 x 240
	localparam int addr_w = 19;

	////////////////////
	// request / write
	////////////////////

	// pixel handed to both engines
	// lane 0 renders screen row 2*row, lane 1 renders 2*row+1
	typedef struct packed {
		logic [coord_w-1:0] x;
		logic [coord_w-1:0] row;
	} pixel_req_t;

	// one strobe writes both banks at the same address
	// data[0] goes to the even bank, data[1] to the odd bank
	typedef struct packed {
		logic                 we;
		logic [addr_w-1:0]    addr;
		color_t [lanes-1:0]   data;
	} fb_write_t;

endpackage

// ==== render_sequencer.sv ====
`timescale 1ns/1ps

module render_sequencer
	import vga_pkg::*;
	import render_pkg::*;
#(
	parameter int h_active = 640,
	parameter int v_active = 480
) (
	input  logic               M10k_pll,
	input  logic               reset,
	input  logic [lanes-1:0]   lane_done,
	input  color_t [lanes-1:0] lane_color,
	output logic               solver_start,
	output pixel_req_t         pixel_req,
	output fb_write_t          fb_write,
	output logic               frame_toggle,
	output logic               scan_enable
);

	// words per bank, also the pixel count of one pass
	localparam int depth = h_active * v_active / 2;
	localparam logic [coord_w-1:0] x_last = coord_w'(h_active - 1);

	typedef enum logic [2:0] {
		s_frame,
		s_start,
		s_settle,
		s_wait,
		s_write,
		s_advance
	} seq_state_e;

	seq_state_e        state;
	logic [addr_w-1:0] pix_addr;
	logic              last_pixel;

	// bank address of the pixel in flight
	assign pix_addr   = addr_w'(h_active) * addr_w'(pixel_req.row) + addr_w'(pixel_req.x);
	assign last_pixel = (pix_addr == addr_w'(depth - 1));

	// both engines kick off on the same cycle
	assign solver_start = (state == s_start);

	////////////////////
	// pixel walk
	////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			state         <= s_frame;
			pixel_req     <= '0;
			fb_write.we   <= 1'b0;
			frame_toggle  <= 1'b0;
			scan_enable   <= 1'b0;
		end else begin
			unique case (state)
				// new pass, scan may run from here on
				s_frame: begin
					pixel_req    <= '0;
					frame_toggle <= ~frame_toggle;
					scan_enable  <= 1'b1;
					state        <= s_start;
				end
				s_start: begin
					state <= s_settle;
				end
				// engines drop done here, stale levels ignored
				s_settle: begin
					state <= s_wait;
				end
				// back-pressure point, hold until every lane finishes
				s_wait: begin
					if (&lane_done) begin
						fb_write.we   <= 1'b1;
						fb_write.addr <= pix_addr;
						fb_write.data <= lane_color;
						state         <= s_write;
					end
				end
				// strobe lasts just this cycle
				s_write: begin
					fb_write.we <= 1'b0;
					state       <= s_advance;
				end
				s_advance: begin
					if (last_pixel) begin
						state <= s_frame;
					end else begin
						// raster order, wrap x into the next row
						if (pixel_req.x == x_last) begin
							pixel_req.x   <= '0;
							pixel_req.row <= pixel_req.row + 1'b1;
						end else begin
							pixel_req.x <= pixel_req.x + 1'b1;
						end
						state <= s_start;
					end
				end
				default: begin
					state <= s_frame;
				end
			endcase
		end
	end

endmodule

// ==== vga_pkg.sv ====
package vga_pkg;

	////////////////////
	// scan geometry
	////////////////////

	// width of every x, y and buffer row coordinate
	localparam int coord_w = 10;

	////////////////////
	// pixel colour
	////////////////////

	// 3-3-2 fields, red in the top bits
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb332_t;

	// one stored byte
	// the buffer keeps raw, the timing generator splits rgb
	typedef union packed {
		logic [7:0] raw;
		rgb332_t    rgb;
	} color_t;

	// registered pins toward the DAC
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       blank_n;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} vga_out_t;

	// one phase enum for both counters
	typedef enum logic [1:0] {
		active,
		front,
		pulse,
		back
	} vga_phase_e;

endpackage

// ==== vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
	import vga_pkg::*;
#(
	parameter int h_active = 640,
	parameter int h_front  = 16,
	parameter int h_pulse  = 96,
	parameter int h_back   = 48,
	parameter int v_active = 480,
	parameter int v_front  = 10,
	parameter int v_pulse  = 2,
	parameter int v_back   = 33
) (
	input  logic               M10k_pll,
	input  logic               reset,
	input  logic               scan_enable,
	input  color_t             pixel,
	output logic [coord_w-1:0] next_x,
	output logic [coord_w-1:0] next_y,
	output vga_out_t           vga
);

	// phase and position inside the phase
	vga_phase_e         h_phase;
	vga_phase_e         v_phase;
	logic [coord_w-1:0] h_count;
	logic [coord_w-1:0] v_count;

	logic h_wrap;
	logic v_wrap;
	logic line_end;
	logic in_active;

	// first pipeline stage, lines up with the buffer read
	logic hs_d1;
	logic vs_d1;
	logic act_d1;

	// porch order: active, front, pulse, back, then around
	function automatic vga_phase_e phase_after(input vga_phase_e ph);
		case (ph)
			active:  return front;
			front:   return pulse;
			pulse:   return back;
			default: return active;
		endcase
	endfunction

	// last count value of a phase
	function automatic logic [coord_w-1:0] phase_last(input vga_phase_e ph, input int n_act,
			input int n_fr, input int n_pu, input int n_ba);
		int n;
		case (ph)
			active:  n = n_act;
			front:   n = n_fr;
			pulse:   n = n_pu;
			default: n = n_ba;
		endcase
		return coord_w'(n - 1);
	endfunction

	assign h_wrap    = (h_count == phase_last(h_phase, h_active, h_front, h_pulse, h_back));
	assign v_wrap    = (v_count == phase_last(v_phase, v_active, v_front, v_pulse, v_back));
	// vertical steps on the last back-porch pixel
	assign line_end  = h_wrap && (h_phase == back);
	assign in_active = (h_phase == active) && (v_phase == active);

	// address of the pixel wanted, zero outside the active area
	assign next_x = in_active ? h_count : '0;
	assign next_y = in_active ? v_count : '0;

	////////////////////
	// scan counters
	////////////////////

	always_ff @(posedge M10k_pll) begin
		// parked at the top-left corner until the first frame starts
		if (reset || !scan_enable) begin
			h_phase <= active;
			h_count <= '0;
			v_phase <= active;
			v_count <= '0;
		end else begin
			if (h_wrap) begin
				h_count <= '0;
				h_phase <= phase_after(h_phase);
			end else begin
				h_count <= h_count + 1'b1;
			end
			// one vertical step per finished line
			if (line_end) begin
				if (v_wrap) begin
					v_count <= '0;
					v_phase <= phase_after(v_phase);
				end else begin
					v_count <= v_count + 1'b1;
				end
			end
		end
	end

	////////////////////
	// output pipeline
	////////////////////

	// stage 1 waits on the buffer, stage 2 is the pin register
	always_ff @(posedge M10k_pll) begin
		if (reset || !scan_enable) begin
			hs_d1       <= 1'b1;
			vs_d1       <= 1'b1;
			act_d1      <= 1'b0;
			vga.hsync   <= 1'b1;
			vga.vsync   <= 1'b1;
			vga.blank_n <= 1'b0;
			vga.red     <= 8'h00;
			vga.green   <= 8'h00;
			vga.blue    <= 8'h00;
		end else begin
			hs_d1       <= (h_phase != pulse);
			vs_d1       <= (v_phase != pulse);
			act_d1      <= in_active;
			vga.hsync   <= hs_d1;
			vga.vsync   <= vs_d1;
			vga.blank_n <= act_d1;
			// 3-3-2 fields into the top of each channel, black in blanking
			vga.red     <= act_d1 ? {pixel.rgb.red, 5'b0} : 8'h00;
			vga.green   <= act_d1 ? {pixel.rgb.green, 5'b0} : 8'h00;
			vga.blue    <= act_d1 ? {pixel.rgb.blue, 6'b0} : 8'h00;
		end
	end

endmodule
